/* list.f */
+incdir+test
src/prbs_pkg.sv
src/lfsr.sv
src/prbs_gen.sv
src/prbs_check.sv
src/prbs_link_top.sv
test/prbs_tb.sv

/* test/prbs_tb_tasks.svh */
`ifndef prbs_tb_tasks_svh
`define prbs_tb_tasks_svh

// --------------------------------------------------
// Reference model of the sequence
// --------------------------------------------------

// One LFSR step, built bit by bit from the tap mask
// The word moves up by one place and the parity of the tapped bits enters at bit 0
function automatic logic [word_width-1:0] next_lfsr(input logic [word_width-1:0] state);
  logic parity;
  logic [word_width-1:0] result;
  parity = 1'b0;
  for (int i = 0; i < word_width; i++) begin
    if (prbs_pkg::lfsr_taps[i]) begin
      parity = parity ^ state[i];
    end
  end
  result[0] = parity;
  for (int i = 1; i < word_width; i++) begin
    result[i] = state[i-1];
  end
  return result;
endfunction

// Number of bits that are set in one word
function automatic int popcount(input logic [word_width-1:0] value);
  int total;
  total = 0;
  for (int i = 0; i < word_width; i++) begin
    total = total + int'(value[i]);
  end
  return total;
endfunction

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------

// Link words
task automatic check_word(input logic [word_width-1:0] got, input logic [word_width-1:0] exp,
                          input string what);
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
  end
endtask

// Checker statistics
task automatic check_count(input logic [cnt_width-1:0] got, input logic [cnt_width-1:0] exp,
                           input string what);
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
  end
endtask

// Single status bits such as locked or an idle link line
task automatic check_flag(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

`endif

/* test/prbs_tb.sv */
`timescale 1ns/100ps

// Testbench for the PRBS link test subsystem
// Inputs change on the falling edge, and the monitor also looks at the falling edge
// where every DUT output has settled since the last rising edge
module prbs_tb;

  localparam int word_width = prbs_pkg::lfsr_width;
  localparam int cnt_width = prbs_pkg::count_width;

  logic clk;
  logic reset;
  logic run;
  logic inject_error;
  logic reseed;
  logic [word_width-1:0] seed_state;
  logic mon_req;
  logic mon_ack;
  logic [word_width-1:0] mon_data;
  logic locked;
  logic [cnt_width-1:0] word_count;
  logic [cnt_width-1:0] bit_error_count;
  logic [cnt_width-1:0] word_error_count;

  int errors = 0;
  int timeouts = 0;
  integer seed_var;

  // Control pulses as the DUT sees them on the rising edge
  int inject_pulses = 0;
  int reseed_pulses = 0;
  logic [word_width-1:0] reseed_value;

  // Progress published by the monitor
  int words_seen = 0;
  int inject_applied = 0;
  int lock_drops = 0;

  // Generator model
  logic prev_req = 1'b0;
  logic prev_ack = 1'b0;
  logic [word_width-1:0] next_exp = prbs_pkg::lfsr_seed;
  logic [word_width-1:0] word_exp;
  logic [word_width-1:0] held_data;
  logic word_flip = 1'b0;
  int inject_used = 0;
  int reseed_used = 0;

  // Checker model
  logic m_locked = 1'b0;
  logic [word_width-1:0] m_pred;
  logic [word_width-1:0] diff;
  int m_miss = 0;
  logic [cnt_width-1:0] m_words = '0;
  logic [cnt_width-1:0] m_bits = '0;
  logic [cnt_width-1:0] m_word_err = '0;

  `include "prbs_tb_tasks.svh"

  prbs_link_top #(
    .Width(word_width),
    .Taps(prbs_pkg::lfsr_taps),
    .Seed(prbs_pkg::lfsr_seed)
  ) UUT (
    .clk(clk),
    .reset(reset),
    .run(run),
    .inject_error(inject_error),
    .reseed(reseed),
    .seed_state(seed_state),
    .mon_req(mon_req),
    .mon_ack(mon_ack),
    .mon_data(mon_data),
    .locked(locked),
    .word_count(word_count),
    .bit_error_count(bit_error_count),
    .word_error_count(word_error_count)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // Count pulses on the edge that latches them, so the monitor knows which word they hit
  always @(posedge clk) begin
    if (inject_error) begin
      inject_pulses <= inject_pulses + 1;
    end
    if (reseed) begin
      reseed_pulses <= reseed_pulses + 1;
      reseed_value <= seed_state;
    end
  end

  // --------------------------------------------------
  // Link monitor and reference model
  // --------------------------------------------------

  always @(negedge clk) begin
    if (!reset) begin
      // Rise of req starts a word; pulses up to this edge belong to it
      if (mon_req && !prev_req) begin
        if (reseed_pulses != reseed_used) begin
          word_exp = reseed_value;
          reseed_used = reseed_pulses;
        end else begin
          word_exp = next_exp;
        end
        next_exp = next_lfsr(word_exp);
        word_flip = (inject_pulses != inject_used);
        inject_used = inject_pulses;
        held_data = mon_data;
      end else if (mon_req || mon_ack) begin
        check_word(mon_data, held_data, "link data during handshake");
      end
      // Rise of ack is where the checker takes the word and updates its outputs
      if (mon_ack && !prev_ack) begin
        check_word(mon_data, word_exp ^ {{(word_width-1){1'b0}}, word_flip}, "link word");
        if (!m_locked) begin
          m_locked = 1'b1;
          m_pred = next_lfsr(mon_data);
          m_miss = 0;
        end else begin
          diff = mon_data ^ m_pred;
          m_pred = next_lfsr(m_pred);
          m_words = m_words + 1'b1;
          m_bits = m_bits + cnt_width'(popcount(diff));
          if (diff != '0) begin
            m_word_err = m_word_err + 1'b1;
            m_miss++;
            // Lock is lost after miss_limit bad words in a row
            if (m_miss == prbs_pkg::miss_limit) begin
              m_locked = 1'b0;
              m_miss = 0;
              lock_drops <= lock_drops + 1;
            end
          end else begin
            m_miss = 0;
          end
        end
        check_flag(locked, m_locked, "locked");
        check_count(word_count, m_words, "word_count");
        check_count(bit_error_count, m_bits, "bit_error_count");
        check_count(word_error_count, m_word_err, "word_error_count");
        words_seen <= words_seen + 1;
        if (word_flip) begin
          inject_applied <= inject_applied + 1;
        end
      end
    end
    prev_req = mon_req;
    prev_ack = mon_ack;
  end

  // --------------------------------------------------
  // Run control
  // --------------------------------------------------

  task automatic finish_run();
    $display("Summary: %0d check failures, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  // Wait until the monitor has counted the given number of words
  task automatic wait_words(input int target);
    int cycles;
    cycles = 0;
    while (words_seen < target && cycles < 8 * target + 40) begin
      @(negedge clk);
      cycles++;
    end
    if (words_seen < target) begin
      $display("Timeout: only %0d of %0d link words arrived", words_seen, target);
      timeouts++;
      finish_run();
    end
  endtask

  // Wait until both link lines are low
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while ((mon_req || mon_ack) && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (mon_req || mon_ack) begin
      $display("Timeout: the link did not go idle after run was dropped");
      timeouts++;
      finish_run();
    end
  endtask

  task automatic pulse_inject();
    inject_error = 1'b1;
    @(negedge clk);
    inject_error = 1'b0;
  endtask

  task automatic pulse_reseed(input logic [word_width-1:0] value);
    seed_state = value;
    reseed = 1'b1;
    @(negedge clk);
    reseed = 1'b0;
  endtask

  initial begin
    int gap;
    int drops_before;
    int stopped_at;
    logic [word_width-1:0] new_seed;
    logic [cnt_width-1:0] errors_at;
    seed_var = 32'h6c57;
    reset = 1'b1;
    run = 1'b0;
    inject_error = 1'b0;
    reseed = 1'b0;
    seed_state = '0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    run = 1'b1;

    // Clean traffic from the reset seed
    wait_words(20);
    check_count(bit_error_count, '0, "bit errors on clean traffic");
    check_count(word_error_count, '0, "word errors on clean traffic");
    check_count(word_count, cnt_width'(words_seen - 1), "compared words");
    check_flag(locked, 1'b1, "locked on clean traffic");

    // Single-bit injections at random gaps, never two in one word slot
    repeat (6) begin
      gap = 4 + ($unsigned($random(seed_var)) % 12);
      repeat (gap) @(negedge clk);
      pulse_inject();
    end
    wait_words(words_seen + 3);
    check_count(cnt_width'(inject_applied), 6, "injected words");
    check_count(word_error_count, cnt_width'(inject_applied), "word errors after injection");
    check_count(bit_error_count, cnt_width'(inject_applied), "bit errors after injection");
    check_flag(locked, 1'b1, "locked after injection");

    // Reseed moves the stream; the checker must drop lock once and relock
    new_seed = $random(seed_var);
    if (new_seed == '0) begin
      new_seed = 16'h0001;
    end
    drops_before = lock_drops;
    pulse_reseed(new_seed);
    wait_words(words_seen + 10);
    check_count(cnt_width'(lock_drops), cnt_width'(drops_before + 1), "lock drops after reseed");
    check_flag(locked, 1'b1, "locked after reseed");
    errors_at = word_error_count;
    wait_words(words_seen + 8);
    check_count(word_error_count, errors_at, "word errors after relock");

    // Stop the stream, stay idle for a while, then resume
    run = 1'b0;
    wait_idle();
    stopped_at = words_seen;
    repeat (12) begin
      @(negedge clk);
      check_flag(mon_req, 1'b0, "mon_req while stopped");
      check_flag(mon_ack, 1'b0, "mon_ack while stopped");
    end
    check_count(cnt_width'(words_seen), cnt_width'(stopped_at), "words while stopped");
    run = 1'b1;
    wait_words(words_seen + 10);
    check_flag(locked, 1'b1, "locked after resume");

    finish_run();
  end

endmodule

/* src/prbs_link_top.sv */
`timescale 1ns/100ps

// PRBS link test subsystem
// A generator streams LFSR words to a checker over a four-phase req/ack link
// The link is internal and mirrored unregistered on the monitor outputs
module prbs_link_top #(
  parameter int Width = prbs_pkg::lfsr_width,
  parameter logic [Width-1:0] Taps = prbs_pkg::lfsr_taps,
  parameter logic [Width-1:0] Seed = prbs_pkg::lfsr_seed
) (
  input logic clk,
  input logic reset,
  // Stream control for the generator
  input logic run,
  input logic inject_error,
  input logic reseed,
  input logic [Width-1:0] seed_state,
  // Copies of the internal link
  output logic mon_req,
  output logic mon_ack,
  output logic [Width-1:0] mon_data,
  // Checker status
  output logic locked,
  output logic [prbs_pkg::count_width-1:0] word_count,
  output logic [prbs_pkg::count_width-1:0] bit_error_count,
  output logic [prbs_pkg::count_width-1:0] word_error_count
);

  logic link_req;
  logic link_ack;
  logic [Width-1:0] link_data;

  // --------------------------------------------------
  // Generator to checker link
  // --------------------------------------------------

  prbs_gen #(
    .Width(Width),
    .Taps(Taps),
    .Seed(Seed)
  ) u_gen (
    .clk(clk),
    .reset(reset),
    .run(run),
    .inject_error(inject_error),
    .reseed(reseed),
    .seed_state(seed_state),
    .link_req(link_req),
    .link_data(link_data),
    .link_ack(link_ack)
  );

  // Checker uses the same taps, it only learns the phase from the data
  prbs_check #(
    .Width(Width),
    .Taps(Taps)
  ) u_check (
    .clk(clk),
    .reset(reset),
    .link_req(link_req),
    .link_data(link_data),
    .link_ack(link_ack),
    .locked(locked),
    .word_count(word_count),
    .bit_error_count(bit_error_count),
    .word_error_count(word_error_count)
  );

  // Monitor outputs follow the link in the same cycle
  assign mon_req = link_req;
  assign mon_ack = link_ack;
  assign mon_data = link_data;

endmodule

/* src/prbs_check.sv */
`timescale 1ns/100ps

// PRBS pattern checker
// Receives words over the four-phase link, locks onto the sequence by seeding its
// own LFSR from a received word, then predicts and compares every later word
module prbs_check #(
  parameter int Width = prbs_pkg::lfsr_width,
  parameter logic [Width-1:0] Taps = prbs_pkg::lfsr_taps
) (
  input logic clk,
  input logic reset,
  input logic link_req,
  input logic [Width-1:0] link_data,
  output logic link_ack,
  // High while received words are being compared against the prediction
  output logic locked,
  // Number of compared words
  output logic [prbs_pkg::count_width-1:0] word_count,
  // Total flipped bits over all compared words
  output logic [prbs_pkg::count_width-1:0] bit_error_count,
  // Compared words with at least one flipped bit
  output logic [prbs_pkg::count_width-1:0] word_error_count
);

  localparam int miss_width = $clog2(prbs_pkg::miss_limit + 1);
  localparam int pop_width = $clog2(Width + 1);

  logic take;
  logic prime;
  logic lfsr_reinit;
  logic lfsr_advance;
  logic [Width-1:0] predicted;
  logic [Width-1:0] diff;
  logic [pop_width-1:0] diff_bits;
  logic mismatch;
  logic [miss_width-1:0] miss_count;
  logic [prbs_pkg::count_width:0] bit_sum;

  // Number of set bits in one word
  function automatic logic [pop_width-1:0] popcount(input logic [Width-1:0] value);
    logic [pop_width-1:0] total;
    total = '0;
    for (int i = 0; i < Width; i++) begin
      total = total + pop_width'(value[i]);
    end
    return total;
  endfunction

  // --------------------------------------------------
  // Link receive side
  // --------------------------------------------------

  // A word is taken on the edge that raises ack
  // Ack falls one cycle after req is seen low
  assign take = link_req && !link_ack;

  always_ff @(posedge clk) begin
    if (reset) begin
      link_ack <= 1'b0;
    end else if (take) begin
      link_ack <= 1'b1;
    end else if (!link_req) begin
      link_ack <= 1'b0;
    end
  end

  // --------------------------------------------------
  // Prediction
  // --------------------------------------------------

  // The LFSR runs one step ahead of the last received word
  // After a lock it is seeded with the received word, then primed by one step
  // in the following cycle, which is well before the next word can arrive
  assign lfsr_reinit = take && !locked;
  assign lfsr_advance = (take && locked) || prime;

  lfsr #(
    .Width(Width),
    .Taps(Taps)
  ) u_lfsr (
    .clk(clk),
    .reset(reset),
    .reinit(lfsr_reinit),
    .initial_state(link_data),
    .advance(lfsr_advance),
    .out(),
    .out_state(predicted)
  );

  assign diff = link_data ^ predicted;
  assign diff_bits = popcount(diff);
  assign mismatch = |diff;

  // One extra bit catches the carry for saturation
  assign bit_sum = {1'b0, bit_error_count} + (prbs_pkg::count_width + 1)'(diff_bits);

  // --------------------------------------------------
  // Lock tracking
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      locked <= 1'b0;
      prime <= 1'b0;
      miss_count <= '0;
    end else begin
      prime <= lfsr_reinit;
      if (take) begin
        if (!locked) begin
          // The seeding word is trusted and not compared
          locked <= 1'b1;
          miss_count <= '0;
        end else if (mismatch) begin
          // Too many misses in a row means the sequence moved, so relock
          if (miss_count == miss_width'(prbs_pkg::miss_limit - 1)) begin
            locked <= 1'b0;
            miss_count <= '0;
          end else begin
            miss_count <= miss_count + 1'b1;
          end
        end else begin
          miss_count <= '0;
        end
      end
    end
  end

  // --------------------------------------------------
  // Statistics
  // --------------------------------------------------

  // All counters stop at all ones
  always_ff @(posedge clk) begin
    if (reset) begin
      word_count <= '0;
      bit_error_count <= '0;
      word_error_count <= '0;
    end else if (take && locked) begin
      if (word_count != '1) begin
        word_count <= word_count + 1'b1;
      end
      bit_error_count <= bit_sum[prbs_pkg::count_width] ? '1 :
                         bit_sum[prbs_pkg::count_width-1:0];
      if (mismatch && (word_error_count != '1)) begin
        word_error_count <= word_error_count + 1'b1;
      end
    end
  end

endmodule

/* src/prbs_gen.sv */
`timescale 1ns/100ps

// PRBS pattern generator
// Each LFSR state goes out as one word over a four-phase req/ack link
// The LFSR only moves between handshakes, so its state is the word on the link
module prbs_gen #(
  parameter int Width = prbs_pkg::lfsr_width,
  parameter logic [Width-1:0] Taps = prbs_pkg::lfsr_taps,
  // State after reset
  parameter logic [Width-1:0] Seed = prbs_pkg::lfsr_seed
) (
  input logic clk,
  input logic reset,
  // Keep sending words while high
  input logic run,
  // One-cycle pulse, flips bit 0 of the next word that starts
  input logic inject_error,
  // One-cycle pulse, reloads the LFSR from seed_state
  input logic reseed,
  input logic [Width-1:0] seed_state,
  output logic link_req,
  output logic [Width-1:0] link_data,
  input logic link_ack
);

  // Handshake sequencer states
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_req = 2'd1;
  localparam logic [1:0] st_drop = 2'd2;

  logic [1:0] hs_state;
  logic inject_pending;
  logic reseed_pending;
  logic flip_bit;
  logic word_done;
  logic do_reseed;
  logic start_word;
  logic lfsr_reinit;
  logic lfsr_advance;
  logic [Width-1:0] lfsr_init;
  logic [Width-1:0] lfsr_state;

  // --------------------------------------------------
  // Handshake control
  // --------------------------------------------------

  // The word ends when req is down and the checker has released ack
  assign word_done = (hs_state == st_drop) && !link_ack;
  assign do_reseed = reseed || reseed_pending;

  // A reseed lands right away when idle, otherwise at the end of the word
  assign lfsr_reinit = do_reseed && ((hs_state == st_idle) || word_done);
  assign lfsr_advance = word_done && !do_reseed;

  // From idle a reseed goes first and the word starts one cycle later
  // At the end of a word the next one starts on the same edge, which gives
  // one word every 4 cycles
  assign start_word = run && (((hs_state == st_idle) && !do_reseed) || word_done);

  always_ff @(posedge clk) begin
    if (reset) begin
      hs_state <= st_idle;
    end else begin
      case (hs_state)
        st_idle: begin
          if (start_word) begin
            hs_state <= st_req;
          end
        end
        st_req: begin
          // Checker has captured the word
          if (link_ack) begin
            hs_state <= st_drop;
          end
        end
        st_drop: begin
          if (word_done) begin
            hs_state <= start_word ? st_req : st_idle;
          end
        end
        default: begin
          hs_state <= st_idle;
        end
      endcase
    end
  end

  // Error injection and reseed requests wait here until they can be applied
  always_ff @(posedge clk) begin
    if (reset) begin
      inject_pending <= 1'b0;
      reseed_pending <= 1'b0;
      flip_bit <= 1'b0;
    end else begin
      if (start_word) begin
        // A pulse in the starting cycle still counts for this word
        flip_bit <= inject_pending || inject_error;
        inject_pending <= 1'b0;
      end else begin
        if (word_done) begin
          flip_bit <= 1'b0;
        end
        if (inject_error) begin
          inject_pending <= 1'b1;
        end
      end
      if (lfsr_reinit) begin
        reseed_pending <= 1'b0;
      end else if (reseed) begin
        reseed_pending <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Sequence source
  // --------------------------------------------------

  // Seed at reset, seed_state for every later reinit
  assign lfsr_init = reset ? Seed : seed_state;

  lfsr #(
    .Width(Width),
    .Taps(Taps)
  ) u_lfsr (
    .clk(clk),
    .reset(reset),
    .reinit(lfsr_reinit),
    .initial_state(lfsr_init),
    .advance(lfsr_advance),
    .out(),
    .out_state(lfsr_state)
  );

  assign link_req = (hs_state == st_req);
  // Data stays stable from the rise of req to the fall of ack
  assign link_data = lfsr_state ^ {{(Width-1){1'b0}}, flip_bit};

endmodule

/* src/lfsr.sv */
`timescale 1ns/100ps

// Fibonacci LFSR
// The next state is the current state shifted left by one, with the MSB dropped
// and the parity of the tapped bits entering as the new LSB
// With a maximal tap mask every nonzero state is visited once per period
module lfsr #(
  // Number of state bits, at least 2
  parameter int Width = prbs_pkg::lfsr_width,
  // Feedback mask, the MSB set for a maximal period
  parameter logic [Width-1:0] Taps = prbs_pkg::lfsr_taps
) (
  input logic clk,
  input logic reset,
  // Load initial_state on the next edge, taking priority over advance
  input logic reinit,
  // State used by both reset and reinit
  input logic [Width-1:0] initial_state,
  // Step the sequence by one
  input logic advance,
  // LSB of the state, the classic single-bit PRBS output
  output logic out,
  // Whole state, used as a word by the link blocks
  output logic [Width-1:0] out_state
);

  logic [Width-1:0] state;
  logic feedback;

  // Parity of the tapped bits becomes the new LSB
  assign feedback = ^(state & Taps);

  // --------------------------------------------------
  // State register
  // --------------------------------------------------

  // Reset and reinit share the same load path
  // Without advance or reinit the state simply holds
  always_ff @(posedge clk) begin
    if (reset || reinit) begin
      state <= initial_state;
    end else if (advance) begin
      state <= {state[Width-2:0], feedback};
    end
  end

  assign out = state[0];
  assign out_state = state;

endmodule

/* src/prbs_pkg.sv */
package prbs_pkg;

  // --------------------------------------------------
  // LFSR and link word geometry
  // --------------------------------------------------

  // State width of every LFSR in the subsystem
  // One link word carries exactly one full LFSR state
  localparam int lfsr_width = 16;

  // Feedback mask for x^16 + x^14 + x^13 + x^11 + 1
  // Bits 15, 13, 12 and 10 are set, which gives the maximal period of 2^16 - 1
  // The MSB must stay set or the period collapses
  localparam logic [lfsr_width-1:0] lfsr_taps = 16'hb400;

  // State loaded into the generator at reset
  // Any nonzero value works, since all-zero is the one state the LFSR never leaves
  localparam logic [lfsr_width-1:0] lfsr_seed = 16'hace1;

  // --------------------------------------------------
  // Checker statistics
  // --------------------------------------------------

  // Width of the word, bit-error and word-error counters
  // All three saturate at all ones instead of wrapping
  localparam int count_width = 24;

  // Consecutive mismatching words that make the checker drop lock
  // A single injected error therefore never costs the lock
  localparam int miss_limit = 3;

endpackage
